//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= qu_core_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/qu_back_end.sv
// Single-issue execute stage; one op in flight, loads take an extra cycle for RAM data
`timescale 1ns/1ps

module qu_back_end
    import qu_isa_pkg::*, qu_core_pkg::*;
    (
        input  logic clk,
        input  logic rst_n,
        input  logic stall,
        input  logic head_valid,
        input  rs_entry_t head,
        output logic issue,
        output logic dmem_en,
        output logic dmem_we,
        output pc_t dmem_addr,
        output word_t dmem_wdata,
        input  word_t dmem_rdata,
        output wb_t wb,
        output logic flush,
        output pc_t flush_pc,
        output logic retire_valid,
        output retire_t retire,
        output logic halt_seen
    );

    word_t a;
    word_t b;
    word_t addr_sum;
    word_t alu_res;
    logic taken;
    logic ld_pend;

    assign a = head.src1.value;
    assign b = head.src2.value;
    assign addr_sum = a + head.uop.imm;
    assign taken = head.uop.op == OP_BEQ && a == b;

    // No issue in the flush cycle, the head is already wrong-path
    assign issue = head_valid && head.src1.ready && head.src2.ready && !ld_pend && !stall && !flush;

    assign dmem_en = issue && (head.uop.op == OP_LW || head.uop.op == OP_SW);
    assign dmem_we = issue && head.uop.op == OP_SW;
    assign dmem_addr = addr_sum[15:0];
    assign dmem_wdata = b;

    always_comb
    begin
        case (head.uop.op)
            OP_ADD:  alu_res = a + b;
            OP_SUB:  alu_res = a - b;
            OP_AND:  alu_res = a & b;
            OP_XOR:  alu_res = a ^ b;
            OP_ADDI: alu_res = addr_sum;
            default: alu_res = '0;
        endcase
    end

    assign wb.valid = retire_valid && retire.wr;
    assign wb.rd = retire.rd;
    assign wb.value = retire.value;
    assign halt_seen = retire_valid && retire.op == OP_HALT;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            retire_valid <= 1'b0;
            ld_pend <= 1'b0;
            flush <= 1'b0;
        end
        else
        begin
            retire_valid <= (issue && head.uop.op != OP_LW) || ld_pend;
            ld_pend <= issue && head.uop.op == OP_LW;
            flush <= issue && taken;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            retire.pc <= head.uop.pc;
            retire.op <= head.uop.op;
            retire.wr <= head.uop.wr;
            retire.rd <= head.uop.rd;
            retire.value <= alu_res;
            flush_pc <= head.uop.pc + 16'd1 + head.uop.imm[15:0];
        end
        if (ld_pend)
            retire.value <= dmem_rdata;     // Load data arrives the cycle after issue
    end

endmodule

//--- hdl/qu_core.sv
// Core top; drive load_en only while fetch is idle, then pulse start; port a fetch, port b data
`timescale 1ns/1ps

module qu_core
    import qu_isa_pkg::*, qu_core_pkg::*;
    #(
        parameter int PC_WIDTH = 10,
        parameter int RS_DEPTH = 4
    )(
        input  logic clk,
        input  logic rst_n,
        input  logic load_en,
        input  pc_t load_addr,
        input  word_t load_data,
        input  logic start,
        input  logic stall,
        output logic retire_valid,
        output retire_t retire,
        output logic halted
    );

    logic fetch_en;
    logic halt_seen;
    logic [PC_WIDTH-1:0] fetch_addr;
    logic [PC_WIDTH-1:0] ram_addra;
    logic ram_ena;
    instr_t fetch_instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    wb_t wb;
    logic flush;
    pc_t flush_pc;
    logic dispatch_valid;
    rs_entry_t dispatch_entry;
    logic full;
    logic head_valid;
    rs_entry_t head;
    logic issue;
    logic dmem_en;
    logic dmem_we;
    pc_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;

    assign ram_ena = load_en | fetch_en;
    assign ram_addra = load_en ? load_addr[PC_WIDTH-1:0] : fetch_addr;  // Load port wins

    qu_startup_ctrl i_startup_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .halt_seen(halt_seen),
        .fetch_en(fetch_en),
        .halted(halted)
    );

    qu_front_end #(
        .PC_WIDTH(PC_WIDTH)
    ) i_front_end (
        .clk(clk),
        .rst_n(rst_n),
        .fetch_en(fetch_en),
        .stall(stall),
        .full(full),
        .fetch_addr(fetch_addr),
        .instr(fetch_instr),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb(wb),
        .flush(flush),
        .flush_pc(flush_pc),
        .dispatch_valid(dispatch_valid),
        .dispatch_entry(dispatch_entry)
    );

    qu_res_st #(
        .RS_DEPTH(RS_DEPTH)
    ) i_res_st (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .dispatch_valid(dispatch_valid),
        .dispatch_entry(dispatch_entry),
        .full(full),
        .wb(wb),
        .head_valid(head_valid),
        .head(head),
        .issue(issue)
    );

    qu_reg_file i_reg_file (
        .clk(clk),
        .rst_n(rst_n),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb(wb)
    );

    qu_back_end i_back_end (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .head_valid(head_valid),
        .head(head),
        .issue(issue),
        .dmem_en(dmem_en),
        .dmem_we(dmem_we),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata),
        .wb(wb),
        .flush(flush),
        .flush_pc(flush_pc),
        .retire_valid(retire_valid),
        .retire(retire),
        .halt_seen(halt_seen)
    );

    qu_dp_ram #(
        .PC_WIDTH(PC_WIDTH)
    ) i_mem (
        .clk(clk),
        .ena(ram_ena),
        .wea(load_en),
        .addra(ram_addra),
        .dina(load_data),
        .douta(fetch_instr),
        .enb(dmem_en),
        .web(dmem_we),
        .addrb(dmem_addr[PC_WIDTH-1:0]),
        .dinb(dmem_wdata),
        .doutb(dmem_rdata)
    );

endmodule

//--- hdl/qu_core_pkg.sv
// Pipeline structs; tags are architectural register numbers since there is no renaming
package qu_core_pkg;

    import qu_isa_pkg::*;

    typedef struct packed {
        opcode_e op;
        reg_addr_t rd;
        logic wr;                       // Clear for non-writing ops and for rd == r0
        pc_t pc;
        word_t imm;                     // Sign-extended
    } uop_t;

    typedef struct packed {
        logic ready;
        reg_addr_t tag;
        word_t value;
    } src_t;

    typedef struct packed {
        uop_t uop;
        src_t src1;
        src_t src2;
    } rs_entry_t;

    typedef struct packed {
        logic valid;
        reg_addr_t rd;
        word_t value;
    } wb_t;

    typedef struct packed {
        pc_t pc;
        opcode_e op;
        logic wr;
        reg_addr_t rd;
        word_t value;                   // Zero for ops that write nothing
    } retire_t;

endpackage

//--- hdl/qu_dp_ram.sv
// Dual-port block RAM, read-first, registered outputs; no init, contents undefined until written
`timescale 1ns/1ps

module qu_dp_ram
    import qu_isa_pkg::*;
    #(
        parameter int PC_WIDTH = 10
    )(
        input  logic clk,
        input  logic ena,
        input  logic wea,
        input  logic [PC_WIDTH-1:0] addra,
        input  word_t dina,
        output word_t douta,
        input  logic enb,
        input  logic web,
        input  logic [PC_WIDTH-1:0] addrb,
        input  word_t dinb,
        output word_t doutb
    );

    word_t mem [2**PC_WIDTH];

    always_ff @(posedge clk)
    begin
        if (ena)
        begin
            if (wea)
                mem[addra] <= dina;
            douta <= mem[addra];
        end
        if (enb)
        begin
            if (web)
                mem[addrb] <= dinb;
            doutb <= mem[addrb];
        end
    end

endmodule

//--- hdl/qu_front_end.sv
// Fetch, decode and dispatch; expects a RAM with one-cycle reads, holds while full or stalled
`timescale 1ns/1ps

module qu_front_end
    import qu_isa_pkg::*, qu_core_pkg::*;
    #(
        parameter int PC_WIDTH = 10
    )(
        input  logic clk,
        input  logic rst_n,
        input  logic fetch_en,
        input  logic stall,
        input  logic full,
        output logic [PC_WIDTH-1:0] fetch_addr,
        input  instr_t instr,
        output reg_addr_t rs1_addr,
        output reg_addr_t rs2_addr,
        input  word_t rs1_data,
        input  word_t rs2_data,
        input  wb_t wb,
        input  logic flush,
        input  pc_t flush_pc,
        output logic dispatch_valid,
        output rs_entry_t dispatch_entry
    );

    pc_t pc;
    pc_t f_pc;
    logic f_valid;
    instr_t d_instr;
    pc_t d_pc;
    logic d_valid;
    logic halt_stop;
    logic [15:0] busy;
    logic [15:0] wb_mask;
    logic [15:0] ready_now;
    uop_t d_uop;
    logic use_rs2;
    logic rd_busy;
    logic d_load;

    function automatic src_t make_src(input logic used, input reg_addr_t r, input word_t data,
                                      input logic rdy);
        src_t s;
        s.ready = !used || r == '0 || rdy;
        s.tag = r;
        s.value = used ? data : '0;
        return s;
    endfunction

    always_comb
    begin
        d_uop.op = d_instr.opcode;
        d_uop.rd = d_instr.rd;
        d_uop.pc = d_pc;
        d_uop.imm = {{16{d_instr.imm[15]}}, d_instr.imm};
        case (d_instr.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LW: d_uop.wr = d_instr.rd != '0;
            default: d_uop.wr = 1'b0;
        endcase
    end

    assign use_rs2 = d_instr.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SW, OP_BEQ};
    assign wb_mask = wb.valid ? (16'd1 << wb.rd) : 16'd0;
    assign ready_now = ~busy | wb_mask;         // Same-cycle writeback counts as ready
    assign rd_busy = d_uop.wr && !ready_now[d_uop.rd];

    assign rs1_addr = d_instr.rs1;
    assign rs2_addr = d_instr.rs2;

    assign dispatch_valid = d_valid && !full && !stall && !rd_busy && !halt_stop;
    assign dispatch_entry.uop = d_uop;
    assign dispatch_entry.src1 = make_src(d_instr.opcode != OP_HALT, d_instr.rs1, rs1_data,
                                          ready_now[d_instr.rs1]);
    assign dispatch_entry.src2 = make_src(use_rs2, d_instr.rs2, rs2_data,
                                          ready_now[d_instr.rs2]);

    // Decode register moves when empty or dispatching
    assign d_load = (!d_valid || dispatch_valid) && !full && !stall;
    // Re-read the held word so the RAM output stays put while decode is blocked
    assign fetch_addr = d_load ? pc[PC_WIDTH-1:0] : f_pc[PC_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= '0;
            f_pc <= '0;
            f_valid <= 1'b0;
            d_valid <= 1'b0;
            halt_stop <= 1'b0;
            busy <= '0;
        end
        else if (flush)
        begin
            pc <= flush_pc;
            f_valid <= 1'b0;
            d_valid <= 1'b0;
            halt_stop <= 1'b0;
            busy <= '0;                         // Everything older has retired
        end
        else
        begin
            if (d_load)
            begin
                f_valid <= fetch_en;
                d_valid <= f_valid;
                if (fetch_en)
                begin
                    f_pc <= pc;
                    pc <= pc + 16'd1;
                end
            end
            if (dispatch_valid && d_uop.op == OP_HALT)
                halt_stop <= 1'b1;
            busy <= (busy & ~wb_mask) | ((dispatch_valid && d_uop.wr) ? (16'd1 << d_uop.rd) : '0);
        end
    end

    always_ff @(posedge clk)
    begin
        if (d_load)
        begin
            d_instr <= instr;
            d_pc <= f_pc;
        end
    end

endmodule

//--- hdl/qu_isa_pkg.sv
// ISA types only; word-addressed 16-bit pc, program and data share one memory, r0 reads as zero
package qu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] reg_addr_t;
    typedef logic [15:0] pc_t;          // Word address, not byte address

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_ADDI = 4'h4,
        OP_LW   = 4'h5,
        OP_SW   = 4'h6,
        OP_BEQ  = 4'h7,                 // Target is pc + 1 + imm
        OP_HALT = 4'h8
    } opcode_e;

    typedef struct packed {
        opcode_e opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [15:0] imm;               // Signed
    } instr_t;

endpackage

//--- hdl/qu_reg_file.sv
// 16 x 32 registers, r0 hardwired to zero, reads see a same-cycle writeback
`timescale 1ns/1ps

module qu_reg_file
    import qu_isa_pkg::*, qu_core_pkg::*;
    (
        input  logic clk,
        input  logic rst_n,
        input  reg_addr_t rs1_addr,
        input  reg_addr_t rs2_addr,
        output word_t rs1_data,
        output word_t rs2_data,
        input  wb_t wb
    );

    word_t regs [16];

    assign rs1_data = (wb.valid && wb.rd == rs1_addr && rs1_addr != '0) ? wb.value : regs[rs1_addr];
    assign rs2_data = (wb.valid && wb.rd == rs2_addr && rs2_addr != '0) ? wb.value : regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end
        else if (wb.valid && wb.rd != '0)
        begin
            regs[wb.rd] <= wb.value;
        end
    end

endmodule

//--- hdl/qu_res_st.sv
// In-order reservation queue; dispatch must respect full, issue only while head_valid
`timescale 1ns/1ps

module qu_res_st
    import qu_core_pkg::*;
    #(
        parameter int RS_DEPTH = 4
    )(
        input  logic clk,
        input  logic rst_n,
        input  logic flush,
        input  logic dispatch_valid,
        input  rs_entry_t dispatch_entry,
        output logic full,
        input  wb_t wb,
        output logic head_valid,
        output rs_entry_t head,
        input  logic issue
    );

    localparam int PTR_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    rs_entry_t q [RS_DEPTH];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;

    function automatic src_t wake(input src_t s, input wb_t w);
        src_t r;
        r = s;
        if (!s.ready && w.valid && w.rd == s.tag)
        begin
            r.ready = 1'b1;
            r.value = w.value;
        end
        return r;
    endfunction

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(RS_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = count == CNT_W'(RS_DEPTH);
    assign head_valid = count != '0;

    always_comb
    begin
        head = q[head_ptr];
        head.src1 = wake(q[head_ptr].src1, wb);     // Lets a dependent op issue back to back
        head.src2 = wake(q[head_ptr].src2, wb);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= '0;
        end
        else if (flush)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (dispatch_valid)
                tail_ptr <= next_ptr(tail_ptr);
            if (issue)
                head_ptr <= next_ptr(head_ptr);
            count <= count + CNT_W'(dispatch_valid) - CNT_W'(issue);
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < RS_DEPTH; i++)
        begin
            q[i].src1 <= wake(q[i].src1, wb);
            q[i].src2 <= wake(q[i].src2, wb);
        end
        if (dispatch_valid)
            q[tail_ptr] <= dispatch_entry;
    end

endmodule

//--- hdl/qu_startup_ctrl.sv
// Fetch stays off after reset until start; once halted only a reset restarts the core
`timescale 1ns/1ps

module qu_startup_ctrl
    (
        input  logic clk,
        input  logic rst_n,
        input  logic start,
        input  logic halt_seen,
        output logic fetch_en,
        output logic halted
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fetch_en <= 1'b0;
            halted <= 1'b0;
        end
        else if (halt_seen)
        begin
            fetch_en <= 1'b0;
            halted <= 1'b1;                 // Sticky
        end
        else if (start && !halted)
        begin
            fetch_en <= 1'b1;
        end
    end

endmodule

//--- tb.f
hdl/qu_isa_pkg.sv
hdl/qu_core_pkg.sv
hdl/qu_startup_ctrl.sv
hdl/qu_front_end.sv
hdl/qu_res_st.sv
hdl/qu_reg_file.sv
hdl/qu_back_end.sv
hdl/qu_dp_ram.sv
hdl/qu_core.sv
verification/qu_core_tb.sv

//--- verification/qu_core_tb.sv
// Programs are reloaded after each reset; loads and stores only touch the preloaded window at 512
`timescale 1ns/1ps

module qu_core_tb
    import qu_isa_pkg::*, qu_core_pkg::*;
    ;

    localparam int PC_WIDTH = 10;
    localparam int MEM_WORDS = 2 ** PC_WIDTH;
    localparam int DATA_BASE = 512;
    localparam int DATA_WORDS = 16;
    localparam int PAD_WORDS = 4;

    logic clk;
    logic rst_n;
    logic load_en;
    pc_t load_addr;
    word_t load_data;
    logic start;
    logic stall;
    logic retire_valid;
    retire_t retire;
    logic halted;

    word_t prog [$];
    retire_t expected [$];
    retire_t exp_ret;
    logic [31:0] lcg_state = 32'hdeb605d9;
    logic started = 1'b0;
    logic stall_on = 1'b0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int budget = 40;

    qu_core #(
        .PC_WIDTH(PC_WIDTH),
        .RS_DEPTH(4)
    ) i_qu_core (
        .clk(clk),
        .rst_n(rst_n),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .start(start),
        .stall(stall),
        .retire_valid(retire_valid),
        .retire(retire),
        .halted(halted)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int k);
        return int'((lcg() >> 8) % 32'(k));
    endfunction

    function automatic word_t data_word(input int addr);
        return 32'hc3a50000 ^ (32'(addr) * 32'h01000193);  // Differs for every address
    endfunction

    function automatic word_t encode(input opcode_e op, input int rd, input int rs1,
                                     input int rs2, input int imm);
        instr_t i;
        i.opcode = op;
        i.rd = 4'(rd);
        i.rs1 = 4'(rs1);
        i.rs2 = 4'(rs2);
        i.imm = 16'(imm);
        return word_t'(i);
    endfunction

    task automatic add_instr(input opcode_e op, input int rd, input int rs1, input int rs2,
                             input int imm);
        prog.push_back(encode(op, rd, rs1, rs2, imm));
    endtask

    // ISA-level model, one retire record per executed instruction
    function automatic void run_reference();
        word_t regs [16];
        word_t mem [MEM_WORDS];
        pc_t pc;
        instr_t ins;
        word_t a;
        word_t b;
        word_t addr;
        retire_t r;
        int steps;
        logic done;
        expected.delete();
        for (int i = 0; i < 16; i++)
            regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = (i >= DATA_BASE && i < DATA_BASE + DATA_WORDS) ? data_word(i) : '0;
        for (int i = 0; i < prog.size(); i++)
            mem[i] = prog[i];
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 4096)
        begin
            ins = instr_t'(mem[pc[PC_WIDTH-1:0]]);
            a = regs[ins.rs1];
            b = regs[ins.rs2];
            addr = a + {{16{ins.imm[15]}}, ins.imm};
            r.pc = pc;
            r.op = ins.opcode;
            r.rd = ins.rd;
            r.value = '0;
            pc = pc + 16'd1;
            case (ins.opcode)
                OP_ADD:  r.value = a + b;
                OP_SUB:  r.value = a - b;
                OP_AND:  r.value = a & b;
                OP_XOR:  r.value = a ^ b;
                OP_ADDI: r.value = addr;
                OP_LW:   r.value = mem[addr[PC_WIDTH-1:0]];
                OP_SW:   mem[addr[PC_WIDTH-1:0]] = b;
                OP_BEQ:
                begin
                    if (a == b)
                        pc = r.pc + 16'd1 + ins.imm;
                end
                default: done = 1'b1;                      // HALT
            endcase
            r.wr = (ins.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LW})
                   && ins.rd != '0;
            if (r.wr)
                regs[ins.rd] = r.value;
            expected.push_back(r);
            steps++;
        end
    endfunction

    task automatic gen_random_program(input int n);
        opcode_e op;
        int rd;
        int rs1;
        int rs2;
        int imm;
        prog.delete();
        for (int i = 0; i < n - 1; i++)
        begin
            op = opcode_e'(4'(rand_below(8)));
            rd = rand_below(8);
            rs1 = rand_below(8);
            rs2 = rand_below(8);
            imm = rand_below(65536);
            if (op == OP_LW || op == OP_SW)
            begin
                rs1 = 0;
                imm = DATA_BASE + rand_below(DATA_WORDS);
            end
            else if (op == OP_BEQ)
            begin
                if (rand_below(2) == 0)
                    rs2 = rs1;                              // Forces a taken branch
                imm = rand_below(4);
                if (imm > n - 2 - i)
                    imm = n - 2 - i;                        // Forward only, never past HALT
            end
            add_instr(op, rd, rs1, rs2, imm);
        end
        add_instr(OP_HALT, 0, 0, 0, 0);
    endtask

    task automatic check_idle(input string phase);
        checks++;
        if (retire_valid != 1'b0 || halted != 1'b0)
        begin
            errors++;
            $display("FAIL %0t: during %s retire_valid %b halted %b, expected both low",
                     $time, phase, retire_valid, halted);
        end
    endtask

    task automatic apply_reset();
        started = 1'b0;
        @(posedge clk);
        rst_n <= 1'b0;
        load_en <= 1'b0;
        start <= 1'b0;
        repeat (8)
        begin
            @(negedge clk);
            check_idle("reset");
            @(posedge clk);
        end
        rst_n <= 1'b1;
    endtask

    task automatic write_word(input int addr, input word_t data);
        load_en <= 1'b1;
        load_addr <= 16'(addr);
        load_data <= data;
        @(negedge clk);
        check_idle("load");
        @(posedge clk);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size() + PAD_WORDS; i++)
            write_word(i, (i < prog.size()) ? prog[i] : encode(OP_HALT, 0, 0, 0, 0));
        for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++)
            write_word(i, data_word(i));
        load_en <= 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            check_idle("idle before start");
            @(posedge clk);
        end
        start <= 1'b1;
        started = 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic run_program(input int post_cycles);
        budget = budget + prog.size() * 20 + 100;
        run_reference();
        apply_reset();
        load_program();
        while (!halted)
            @(negedge clk);
        checks++;
        if (expected.size() != 0)
        begin
            errors++;
            $display("FAIL %0t: halted rose with %0d retirements still expected",
                     $time, expected.size());
        end
        repeat (post_cycles)
            @(negedge clk);
        checks++;
        if (expected.size() != 0)
        begin
            errors++;
            $display("Missing %0d retirements at %0t, first expected pc %0d",
                     expected.size(), $time, expected[0].pc);
        end
        checks++;
        if (!halted)
        begin
            errors++;
            $display("FAIL %0t: halted dropped after HALT retired", $time);
        end
    endtask

    task automatic alu_dependency_chain();
        prog.delete();
        add_instr(OP_ADDI, 1, 0, 0, 5);
        add_instr(OP_ADDI, 2, 0, 0, -3);
        add_instr(OP_ADD, 3, 1, 2, 0);
        add_instr(OP_SUB, 4, 3, 1, 0);
        add_instr(OP_XOR, 5, 4, 2, 0);
        add_instr(OP_AND, 6, 4, 1, 0);
        add_instr(OP_ADDI, 0, 1, 0, 7);                     // Write to r0 is dropped
        add_instr(OP_ADD, 7, 0, 1, 0);
        add_instr(OP_ADD, 7, 7, 7, 0);
        add_instr(OP_HALT, 0, 0, 0, 0);
        run_program(10);
    endtask

    task automatic store_then_load();
        prog.delete();
        add_instr(OP_ADDI, 1, 0, 0, 16'h1234);
        add_instr(OP_ADDI, 2, 0, 0, DATA_BASE);
        add_instr(OP_SW, 0, 2, 1, 3);
        add_instr(OP_LW, 3, 2, 0, 3);
        add_instr(OP_ADD, 4, 3, 3, 0);
        add_instr(OP_LW, 5, 0, 0, DATA_BASE + 8);
        add_instr(OP_XOR, 6, 5, 3, 0);
        add_instr(OP_HALT, 0, 0, 0, 0);
        run_program(10);
    endtask

    task automatic branch_skip_and_fallthrough();
        prog.delete();
        add_instr(OP_ADDI, 1, 0, 0, 7);
        add_instr(OP_ADDI, 2, 0, 0, 7);
        add_instr(OP_BEQ, 0, 1, 2, 2);                      // Taken
        add_instr(OP_ADDI, 3, 0, 0, 1);
        add_instr(OP_ADDI, 4, 0, 0, 1);
        add_instr(OP_ADDI, 5, 0, 0, 9);
        add_instr(OP_BEQ, 0, 1, 5, 1);                      // Not taken
        add_instr(OP_ADDI, 6, 0, 0, 2);
        add_instr(OP_HALT, 0, 0, 0, 0);
        run_program(10);
    endtask

    task automatic stalled_program_to_halt();
        gen_random_program(24);
        stall_on = 1'b1;
        run_program(20);
        stall_on = 1'b0;
    endtask

    task automatic random_program_sweep();
        for (int t = 0; t < 10; t++)
        begin
            gen_random_program(12 + rand_below(29));
            run_program(10);
        end
    endtask

    always @(posedge clk)
    begin
        if (stall_on)
            stall <= rand_below(8) < 3;
        else
            stall <= 1'b0;
    end

    always @(negedge clk)
    begin
        if (rst_n && retire_valid)
        begin
            if (!started)
            begin
                errors++;
                $display("Retirement seen before start at %0t", $time);
            end
            else if (expected.size() == 0)
            begin
                errors++;
                $display("Extra retirement at %0t, pc %0d", $time, retire.pc);
            end
            else
            begin
                exp_ret = expected.pop_front();
                checks++;
                if (retire != exp_ret)
                begin
                    errors++;
                    $display("FAIL %0t: retire pc %0d op %0d rd %0d wr %b value %h",
                             $time, retire.pc, retire.op, retire.rd, retire.wr,
                             retire.value);
                    $display("  expected pc %0d op %0d rd %0d wr %b value %h",
                             exp_ret.pc, exp_ret.op, exp_ret.rd, exp_ret.wr, exp_ret.value);
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > budget)
        begin
            $display("Timeout: run exceeded %0d cycles without finishing", budget);
            $display("checks %0d errors %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        start = 1'b0;
        stall = 1'b0;
        alu_dependency_chain();
        store_then_load();
        branch_skip_and_fallthrough();
        stalled_program_to_halt();
        random_program_sweep();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
